/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tile_video
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* color_lut_ram.sv */
module color_lut_ram
   import tile_pkg::*;
(
   input  logic              CLK_4PN,
   input  logic              rst,
   input  logic              lut_valid,
   input  lut_wr_t           lut_wr,
   output logic              lut_ready,
   input  logic [lut_aw-1:0] rd_addr,
   output logic [col_w-1:0]  rd_data
);

   // Colour per row band and tile column
   logic [col_w-1:0] mem [lut_depth];

   // ----------------------------------------
   // Config write port
   // ----------------------------------------

   // Ready comes up one clock after reset release and stays up
   always_ff @(posedge CLK_4PN)
   begin
      if (rst)
         lut_ready <= 1'b0;
      else
         lut_ready <= 1'b1;
   end

   // Committed on the accepting edge
   always_ff @(posedge CLK_4PN)
   begin
      if (lut_valid && lut_ready)
         mem[lut_wr.addr] <= lut_wr.color;
   end

   // ----------------------------------------
   // Display read port
   // ----------------------------------------

   // Registered, independent of the write side
   always_ff @(posedge CLK_4PN)
   begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* raster_counter.sv */
module raster_counter
   import vid_timing_pkg::*;
(
   input  logic    CLK_4PN,
   input  logic    rst,
   output raster_t raster
);

   // Next counter values
   logic [cnt_w-1:0] h_nxt;
   logic [cnt_w-1:0] v_nxt;
   logic             h_wrap;

   // ----------------------------------------
   // Next position
   // ----------------------------------------

   // End of line
   assign h_wrap = (raster.h_cnt == h_total - 9'd1);

   always_comb
   begin
      h_nxt = raster.h_cnt + 9'd1;
      v_nxt = raster.v_cnt;
      if (h_wrap)
      begin
         h_nxt = '0;
         // Line step at the end of each line, frame wrap at v_total
         if (raster.v_cnt == v_total - 9'd1)
            v_nxt = '0;
         else
            v_nxt = raster.v_cnt + 9'd1;
      end
   end

   // ----------------------------------------
   // Registered raster state
   // ----------------------------------------

   // Flags come from the next counts so they line up with them
   always_ff @(posedge CLK_4PN)
   begin
      if (rst)
      begin
         raster.h_cnt  <= '0;
         raster.v_cnt  <= '0;
         raster.hblank <= 1'b0;
         raster.vblank <= 1'b0;
         // Line 0 column 0 is inside the fetch window
         raster.fetch  <= 1'b1;
      end
      else
      begin
         raster.h_cnt  <= h_nxt;
         raster.v_cnt  <= v_nxt;
         raster.hblank <= (h_nxt >= h_active);
         raster.vblank <= (v_nxt >= v_active);
         raster.fetch  <= (h_nxt < h_active) && (v_nxt < v_active);
      end
   end

endmodule

/* tb_tile_video.sv */
module tb_tile_video
   import vid_timing_pkg::*;
   import tile_pkg::*;
();

   localparam int frame_clks = int'(h_total) * int'(v_total);

   logic              CLK_4PN;
   logic              rst;
   logic              flip;
   logic              cpu_valid;
   bus_req_t          cpu_req;
   logic              cpu_ready;
   logic              rsp_valid;
   bus_rsp_t          cpu_rsp;
   logic              lut_valid;
   lut_wr_t           lut_wr;
   logic              lut_ready;
   logic [pat_aw-1:0] pat_addr;
   logic [data_w-1:0] pat_d1 = '0;
   logic [data_w-1:0] pat_d2 = '0;
   pixel_t            pix;
   logic              vram_busy;

   // Reference copies of the name RAM and colour LUT
   logic [7:0] name_mem [1024];
   logic       name_ok [1024];
   logic [3:0] lut_mem [256];
   int         errors = 0;
   int         tests_run = 0;
   int         tests_failed = 0;
   int         seed;

   tile_video_top UUT (.*);

   // ----------------------------------------
   // Pattern ROM model, one clock latency
   // ----------------------------------------

   // Plane 1 low byte, plane 2 low byte XOR high bits repeated
   function automatic logic [15:0] rom_planes(input logic [10:0] a);
      logic [2:0] hi;
      hi = a[10:8];
      return {a[7:0], a[7:0] ^ {hi[1:0], hi, hi}};
   endfunction

   always @(posedge CLK_4PN)
      {pat_d1, pat_d2} <= rom_planes(pat_addr);

   initial
   begin
      CLK_4PN = 1'b0;
      forever #2 CLK_4PN = ~CLK_4PN;
   end

   // Four frames covers every test with margin
   initial
   begin
      #(4 * frame_clks * 4);
      $display("Timeout: simulation ran past four frames");
      $display("Result: FAILED");
      $finish;
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------

   task automatic tick;
      @(posedge CLK_4PN);
      #1;
   endtask

   task automatic report_mismatch(input string sig, input int got, input int exp);
      errors++;
      $display("FAILED t=%0t %s got %0h expected %0h", $time, sig, got, exp);
   endtask

   task automatic end_test(input string name, input int err_start);
      tests_run++;
      if (errors > err_start)
      begin
         tests_failed++;
         $display("test %s: failed", name);
      end
      else
         $display("test %s: ok", name);
   endtask

   // One CPU transfer, waits while cpu_ready is low
   task automatic cpu_access(input logic wr, input logic [9:0] addr, input logic [7:0] data);
      cpu_valid     = 1'b1;
      cpu_req.write = wr;
      cpu_req.addr  = addr;
      cpu_req.data  = data;
      while (!cpu_ready)
         tick;
      tick;
      cpu_valid = 1'b0;
      if (wr)
      begin
         name_mem[addr] = data;
         name_ok[addr]  = 1'b1;
         if (rsp_valid !== 1'b0)
            report_mismatch("rsp_valid", 32'(rsp_valid), 0);
      end
      else
      begin
         if (rsp_valid !== 1'b1)
            report_mismatch("rsp_valid", 32'(rsp_valid), 1);
         if (cpu_rsp.data !== name_mem[addr])
            report_mismatch("cpu_rsp.data", 32'(cpu_rsp.data), 32'(name_mem[addr]));
      end
   endtask

   task automatic lut_write(input logic [7:0] addr, input logic [3:0] color);
      lut_valid    = 1'b1;
      lut_wr.addr  = addr;
      lut_wr.color = color;
      if (lut_ready !== 1'b1)
         report_mismatch("lut_ready", 32'(lut_ready), 1);
      tick;
      lut_valid     = 1'b0;
      lut_mem[addr] = color;
   endtask

   // Colour and index for screen column x of a line
   function automatic logic [5:0] expect_pixel(input int line, input int x, input logic flp);
      logic [8:0]  ln;
      logic [4:0]  col;
      logic [2:0]  b;
      logic [7:0]  nm;
      logic [15:0] pl;
      ln  = 9'(line);
      col = flp ? ~x[7:3] : x[7:3];
      b   = flp ? x[2:0] : 3'd7 - x[2:0];
      nm  = name_mem[{ln[7:3], col}];
      pl  = rom_planes({nm, ln[2:0]});
      return {lut_mem[{ln[7:5], col}], pl[8 + 32'(b)], pl[b]};
   endfunction

   // ----------------------------------------
   // Directed tests
   // ----------------------------------------

   task automatic test_reset;
      int e;
      e = errors;
      repeat (8) tick;
      if (rsp_valid !== 1'b0)
         report_mismatch("rsp_valid", 32'(rsp_valid), 0);
      if (pix.valid !== 1'b0)
         report_mismatch("pix.valid", 32'(pix.valid), 0);
      if (lut_ready !== 1'b0)
         report_mismatch("lut_ready", 32'(lut_ready), 0);
      rst = 1'b0;
      tick;
      if (lut_ready !== 1'b1)
         report_mismatch("lut_ready", 32'(lut_ready), 1);
      end_test("reset", e);
   endtask

   task automatic test_write_read;
      int e;
      e = errors;
      cpu_access(1'b1, 10'h000, 8'h3c);
      cpu_access(1'b1, 10'h155, 8'ha5);
      cpu_access(1'b1, 10'h2aa, 8'h5a);
      cpu_access(1'b1, 10'h3ff, 8'hc3);
      cpu_access(1'b0, 10'h000, 8'h00);
      cpu_access(1'b0, 10'h155, 8'h00);
      cpu_access(1'b0, 10'h2aa, 8'h00);
      cpu_access(1'b0, 10'h3ff, 8'h00);
      end_test("write_read", e);
   endtask

   task automatic test_fetch_wait;
      int e;
      int waited;
      e = errors;
      waited = 0;
      // Find the start of a fetch window
      while (vram_busy)
         tick;
      while (!vram_busy)
         tick;
      cpu_valid     = 1'b1;
      cpu_req.write = 1'b0;
      cpu_req.addr  = 10'h155;
      cpu_req.data  = 8'h00;
      while (vram_busy)
      begin
         if (cpu_ready !== 1'b0)
            report_mismatch("cpu_ready", 32'(cpu_ready), 0);
         if (rsp_valid !== 1'b0)
            report_mismatch("rsp_valid", 32'(rsp_valid), 0);
         waited++;
         tick;
      end
      if (cpu_ready !== 1'b1)
         report_mismatch("cpu_ready", 32'(cpu_ready), 1);
      // Request raised at column 0 waits out the whole visible span
      if (waited != int'(h_active))
         report_mismatch("vram_busy cycles", waited, int'(h_active));
      tick;
      cpu_valid = 1'b0;
      if (rsp_valid !== 1'b1)
         report_mismatch("rsp_valid", 32'(rsp_valid), 1);
      if (cpu_rsp.data !== 8'ha5)
         report_mismatch("cpu_rsp.data", 32'(cpu_rsp.data), 32'ha5);
      end_test("fetch_wait", e);
   endtask

   // Compare one visible line at h_cnt 8 to 263
   task automatic check_line(input string name, input int line, input logic flp);
      int e;
      logic [5:0] exp;
      e = errors;
      for (int k = 0; k < 32; k++)
      begin
         cpu_access(1'b1, {5'(line >> 3), 5'(k)}, 8'((k * 29 + 7) & 255));
         lut_write({3'(line >> 5), 5'(k)}, 4'(k * 7 + 3));
      end
      flip = flp;
      while (!(UUT.raster.v_cnt == 9'(line) && UUT.raster.h_cnt == 9'd8))
         tick;
      for (int x = 0; x < 256; x++)
      begin
         exp = expect_pixel(line, x, flp);
         if (pix.valid !== 1'b1)
            report_mismatch("pix.valid", 32'(pix.valid), 1);
         if (pix.color !== exp[5:2])
            report_mismatch("pix.color", 32'(pix.color), 32'(exp[5:2]));
         if (pix.index !== exp[1:0])
            report_mismatch("pix.index", 32'(pix.index), 32'(exp[1:0]));
         tick;
      end
      if (pix.valid !== 1'b0)
         report_mismatch("pix.valid", 32'(pix.valid), 0);
      tick;
      flip = 1'b0;
      end_test(name, e);
   endtask

   task automatic test_random;
      int e;
      int r;
      logic [9:0] a;
      e = errors;
      for (int i = 0; i < 200; i++)
      begin
         r = $random(seed);
         a = r[9:0];
         // Unwritten addresses get a write first
         cpu_access(r[10] | !name_ok[a], a, r[23:16]);
      end
      end_test("random", e);
   endtask

   initial
   begin
      seed      = 32'haae6_4ea5;
      rst       = 1'b1;
      flip      = 1'b0;
      cpu_valid = 1'b0;
      cpu_req   = '0;
      lut_valid = 1'b0;
      lut_wr    = '0;
      for (int i = 0; i < 1024; i++)
         name_ok[i] = 1'b0;
      test_reset;
      test_write_read;
      test_fetch_wait;
      check_line("line", 36, 1'b0);
      check_line("line_flip", 37, 1'b1);
      test_random;
      $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

/* tile_name_ram.sv */
module tile_name_ram
   import tile_pkg::*;
(
   input  logic               CLK_4PN,
   input  logic [name_aw-1:0] addr,
   input  logic               we,
   input  logic [data_w-1:0]  wdata,
   output logic [data_w-1:0]  rdata
);

   // ----------------------------------------
   // Storage
   // ----------------------------------------

   // One name byte per tile, row-major
   logic [data_w-1:0] mem [name_depth];

   // ----------------------------------------
   // Single port access
   // ----------------------------------------

   // Write on the edge
   always_ff @(posedge CLK_4PN)
   begin
      if (we)
         mem[addr] <= wdata;
   end

   // Registered read, one cycle latency
   // Read during write returns the old byte
   always_ff @(posedge CLK_4PN)
   begin
      rdata <= mem[addr];
   end

endmodule

/* tile_pkg.sv */
package tile_pkg;

   // ----------------------------------------
   // Memory sizes
   // ----------------------------------------

   // Name RAM, 32 by 32 tiles
   localparam int unsigned name_aw    = 10;
   localparam int unsigned name_depth = 1 << name_aw;

   // Colour lookup, 8 row bands by 32 columns
   localparam int unsigned lut_aw     = 8;
   localparam int unsigned lut_depth  = 1 << lut_aw;

   // Pattern ROM, name byte then line-in-tile
   localparam int unsigned pat_aw     = 11;

   // Byte lanes and colour width
   localparam int unsigned data_w     = 8;
   localparam int unsigned col_w      = 4;

   // ----------------------------------------
   // CPU port to the name RAM
   // ----------------------------------------

   typedef struct packed {
      logic              write;
      logic [name_aw-1:0] addr;
      logic [data_w-1:0]  data;
   } bus_req_t;

   // Read data, qualified by rsp_valid
   typedef struct packed {
      logic [data_w-1:0] data;
   } bus_rsp_t;

   // Colour LUT load word
   typedef struct packed {
      logic [lut_aw-1:0] addr;
      logic [col_w-1:0]  color;
   } lut_wr_t;

   // ----------------------------------------
   // Video output, one per clock
   // ----------------------------------------

   typedef struct packed {
      logic             valid;
      logic [col_w-1:0] color;
      // Bit 1 from plane 1, bit 0 from plane 2
      logic [1:0]       index;
   } pixel_t;

endpackage

/* tile_shifter.sv */
module tile_shifter
   import vid_timing_pkg::*;
   import tile_pkg::*;
(
   input  logic              CLK_4PN,
   input  logic              rst,
   input  raster_t           raster,
   input  logic              flip,
   input  logic [data_w-1:0] name,
   output logic [pat_aw-1:0] pat_addr,
   output logic [lut_aw-1:0] lut_addr,
   input  logic [data_w-1:0] pat_d1,
   input  logic [data_w-1:0] pat_d2,
   input  logic [col_w-1:0]  color,
   output pixel_t            pix
);

   // Position inside the current tile
   logic [2:0]           phase;
   logic [4:0]           col;
   // Holding registers, filled in phase 2
   logic [data_w-1:0]    hold_d1;
   logic [data_w-1:0]    hold_d2;
   logic [col_w-1:0]     hold_col;
   // Plane shifters and the colour for the tile on screen
   logic [data_w-1:0]    shift_d1;
   logic [data_w-1:0]    shift_d2;
   logic [col_w-1:0]     color_q;
   // Fetch window delayed to pixel time
   logic [pix_delay-1:0] fetch_dly;

   assign phase = raster.h_cnt[2:0];
   // Mirrored column order under flip
   assign col   = raster.h_cnt[7:3] ^ {5{flip}};

   // ----------------------------------------
   // Phase 1 addresses
   // ----------------------------------------

   // Name byte is on the RAM output from phase 1, ROM answers in phase 2
   assign pat_addr = {name, raster.v_cnt[2:0]};
   // Colour per 32-line band, also back in phase 2
   assign lut_addr = {raster.v_cnt[7:5], col};

   // Phase 2 capture of planes and colour
   always_ff @(posedge CLK_4PN)
   begin
      if (raster.fetch && phase == 3'd2)
      begin
         hold_d1  <= pat_d1;
         hold_d2  <= pat_d2;
         hold_col <= color;
      end
   end

   // ----------------------------------------
   // Shifters
   // ----------------------------------------

   // Load on the edge ending phase 7, shift on every other edge
   always_ff @(posedge CLK_4PN)
   begin
      if (raster.fetch && phase == 3'd7)
      begin
         shift_d1 <= hold_d1;
         shift_d2 <= hold_d2;
         color_q  <= hold_col;
      end
      else if (flip)
      begin
         // Mirrored, bit 0 goes out first
         shift_d1 <= {1'b0, shift_d1[data_w-1:1]};
         shift_d2 <= {1'b0, shift_d2[data_w-1:1]};
      end
      else
      begin
         shift_d1 <= {shift_d1[data_w-2:0], 1'b0};
         shift_d2 <= {shift_d2[data_w-2:0], 1'b0};
      end
   end

   // Valid runs pix_delay clocks behind the fetch window
   always_ff @(posedge CLK_4PN)
   begin
      if (rst)
         fetch_dly <= '0;
      else
         fetch_dly <= {fetch_dly[pix_delay-2:0], raster.fetch};
   end

   // ----------------------------------------
   // Pixel out
   // ----------------------------------------

   always_comb
   begin
      pix.valid = fetch_dly[pix_delay-1];
      pix.color = '0;
      pix.index = '0;
      // Colour and index stay zero outside the visible span
      if (pix.valid)
      begin
         pix.color = color_q;
         if (flip)
            pix.index = {shift_d1[0], shift_d2[0]};
         else
            pix.index = {shift_d1[data_w-1], shift_d2[data_w-1]};
      end
   end

endmodule

/* tile_video_asserts.sv */
module tile_video_asserts
   import vid_timing_pkg::*;
   import tile_pkg::*;
(
   input logic    CLK_4PN,
   input logic    rst,
   input raster_t raster,
   input logic    cpu_valid,
   input logic    cpu_ready,
   input logic    cpu_write,
   input logic    rsp_valid,
   input pixel_t  pix
);

   // ----------------------------------------
   // Name RAM arbitration
   // ----------------------------------------

   // Display owns the RAM on visible lines below h_active
   a_no_grant_in_fetch : assert property (@(posedge CLK_4PN) disable iff (rst)
      cpu_ready |-> (raster.h_cnt >= h_active || raster.v_cnt >= v_active))
      else $error("cpu_ready high inside the fetch window");

   // Read response exactly one clock after the accepting edge
   a_rsp_one_cycle : assert property (@(posedge CLK_4PN) disable iff (rst)
      rsp_valid == $past(cpu_valid && cpu_ready && !cpu_write))
      else $error("rsp_valid does not follow an accepted read by one cycle");

   // ----------------------------------------
   // Pixel output
   // ----------------------------------------

   // Valid pixels only in the visible span, pix_delay clocks late
   a_pixel_window : assert property (@(posedge CLK_4PN) disable iff (rst)
      pix.valid |-> (raster.v_cnt < v_active && raster.h_cnt >= pix_delay
                     && raster.h_cnt < h_active + pix_delay))
      else $error("pix.valid high outside the delayed visible span");

endmodule

// Arbiter side, pixel input tied off
bind vram_arbiter tile_video_asserts u_arb_asserts (
   .CLK_4PN   (CLK_4PN),
   .rst       (rst),
   .raster    (raster),
   .cpu_valid (cpu_valid),
   .cpu_ready (cpu_ready),
   .cpu_write (cpu_req.write),
   .rsp_valid (rsp_valid),
   .pix       ('0)
);

// Shifter side, CPU inputs tied off
bind tile_shifter tile_video_asserts u_pix_asserts (
   .CLK_4PN   (CLK_4PN),
   .rst       (rst),
   .raster    (raster),
   .cpu_valid (1'b0),
   .cpu_ready (1'b0),
   .cpu_write (1'b0),
   .rsp_valid (1'b0),
   .pix       (pix)
);

/* tile_video_top.sv */
module tile_video_top
   import vid_timing_pkg::*;
   import tile_pkg::*;
(
   input  logic              CLK_4PN,
   input  logic              rst,
   input  logic              flip,
   // CPU port to the name RAM
   input  logic              cpu_valid,
   input  bus_req_t          cpu_req,
   output logic              cpu_ready,
   output logic              rsp_valid,
   output bus_rsp_t          cpu_rsp,
   // Colour LUT load
   input  logic              lut_valid,
   input  lut_wr_t           lut_wr,
   output logic              lut_ready,
   // External pattern ROM
   output logic [pat_aw-1:0] pat_addr,
   input  logic [data_w-1:0] pat_d1,
   input  logic [data_w-1:0] pat_d2,
   // Video out
   output pixel_t            pix,
   output logic              vram_busy
);

   raster_t            raster;
   // Name RAM port
   logic [name_aw-1:0] ram_addr;
   logic               ram_we;
   logic [data_w-1:0]  ram_wdata;
   logic [data_w-1:0]  ram_rdata;
   // Colour LUT display read
   logic [lut_aw-1:0]  lut_addr;
   logic [col_w-1:0]   lut_color;

   // Busy while the display owns the name RAM
   assign vram_busy = raster.fetch;

   // ----------------------------------------
   // Timing and name RAM
   // ----------------------------------------

   raster_counter u_raster (
      .CLK_4PN (CLK_4PN),
      .rst     (rst),
      .raster  (raster)
   );

   vram_arbiter u_arb (
      .CLK_4PN   (CLK_4PN),
      .rst       (rst),
      .raster    (raster),
      .cpu_valid (cpu_valid),
      .cpu_req   (cpu_req),
      .cpu_ready (cpu_ready),
      .rsp_valid (rsp_valid),
      .cpu_rsp   (cpu_rsp),
      .flip      (flip),
      .ram_addr  (ram_addr),
      .ram_we    (ram_we),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata)
   );

   tile_name_ram u_name_ram (
      .CLK_4PN (CLK_4PN),
      .addr    (ram_addr),
      .we      (ram_we),
      .wdata   (ram_wdata),
      .rdata   (ram_rdata)
   );

   // ----------------------------------------
   // Colour and pixel path
   // ----------------------------------------

   color_lut_ram u_lut (
      .CLK_4PN   (CLK_4PN),
      .rst       (rst),
      .lut_valid (lut_valid),
      .lut_wr    (lut_wr),
      .lut_ready (lut_ready),
      .rd_addr   (lut_addr),
      .rd_data   (lut_color)
   );

   // RAM output doubles as the fetched name byte
   tile_shifter u_shifter (
      .CLK_4PN  (CLK_4PN),
      .rst      (rst),
      .raster   (raster),
      .flip     (flip),
      .name     (ram_rdata),
      .pat_addr (pat_addr),
      .lut_addr (lut_addr),
      .pat_d1   (pat_d1),
      .pat_d2   (pat_d2),
      .color    (lut_color),
      .pix      (pix)
   );

endmodule

/* vid_timing_pkg.sv */
package vid_timing_pkg;

   // ----------------------------------------
   // Raster geometry, one pixel per clock
   // ----------------------------------------

   // Counter width covers both axes
   localparam int unsigned cnt_w = 9;

   // Horizontal line, visible part first
   localparam logic [cnt_w-1:0] h_total  = 9'd320;
   localparam logic [cnt_w-1:0] h_active = 9'd256;

   // Vertical frame, visible lines first
   localparam logic [cnt_w-1:0] v_total  = 9'd264;
   localparam logic [cnt_w-1:0] v_active = 9'd224;

   // Counter position to displayed pixel
   // One tile of fetch latency ahead of the shifters
   localparam int unsigned pix_delay = 8;

   // ----------------------------------------
   // Raster state as seen by the display side
   // ----------------------------------------

   // All fields are registered together in the counter
   typedef struct packed {
      logic [cnt_w-1:0] h_cnt;
      logic [cnt_w-1:0] v_cnt;
      logic             hblank;
      logic             vblank;
      // Visible line and h_cnt below h_active
      logic             fetch;
   } raster_t;

endpackage

/* vlog.f */
vid_timing_pkg.sv
tile_pkg.sv
raster_counter.sv
vram_arbiter.sv
tile_name_ram.sv
color_lut_ram.sv
tile_shifter.sv
tile_video_top.sv
tile_video_asserts.sv
tb_tile_video.sv

/* vram_arbiter.sv */
module vram_arbiter
   import vid_timing_pkg::*;
   import tile_pkg::*;
(
   input  logic               CLK_4PN,
   input  logic               rst,
   input  raster_t            raster,
   input  logic               cpu_valid,
   input  bus_req_t           cpu_req,
   output logic               cpu_ready,
   output logic               rsp_valid,
   output bus_rsp_t           cpu_rsp,
   input  logic               flip,
   output logic [name_aw-1:0] ram_addr,
   output logic               ram_we,
   output logic [data_w-1:0]  ram_wdata,
   input  logic [data_w-1:0]  ram_rdata
);

   // Tile column, mirrored under flip
   logic [4:0]         fetch_col;
   // Display-side name address
   logic [name_aw-1:0] fetch_addr;
   // CPU transfer on this edge
   logic               accept;
   // Read issued on the previous edge
   logic               rd_pend;

   // ----------------------------------------
   // Display fetch address
   // ----------------------------------------

   // Row from v_cnt 7..3, column from h_cnt 7..3
   assign fetch_col  = raster.h_cnt[7:3] ^ {5{flip}};
   assign fetch_addr = {raster.v_cnt[7:3], fetch_col};

   // ----------------------------------------
   // CPU grant
   // ----------------------------------------

   // CPU owns the RAM only outside the fetch window
   assign cpu_ready = ~raster.fetch;
   assign accept    = cpu_valid & cpu_ready;

   // Address mux, display wins while fetching
   assign ram_addr  = raster.fetch ? fetch_addr : cpu_req.addr;

   // Write lands on the accepting edge
   assign ram_we    = accept & cpu_req.write;
   assign ram_wdata = cpu_req.data;

   // ----------------------------------------
   // Read response
   // ----------------------------------------

   // Marker lines up with the one-cycle RAM latency
   always_ff @(posedge CLK_4PN)
   begin
      if (rst)
         rd_pend <= 1'b0;
      else
         rd_pend <= accept & ~cpu_req.write;
   end

   assign rsp_valid    = rd_pend;
   // RAM output holds the CPU read in the cycle after acceptance
   assign cpu_rsp.data = ram_rdata;

endmodule
